//--- common/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// address split is tag | index | offset

// upper address bits kept per line
`define CACHE_TAG_W     20

// one set per index value
`define CACHE_INDEX_W   8

// byte offset inside a 16-byte line
`define CACHE_OFFSET_W  4

`define CACHE_SETS      256

// 32-bit words per line
`define CACHE_WORDS     4

// nonzero start value of the victim LFSR
`define CACHE_LFSR_SEED 23'h4a528a

`endif

//--- common/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [31:0]                 addr_t;
    typedef logic [`CACHE_TAG_W-1:0]     tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]   index_t;
    typedef logic [1:0]                  word_sel_t;
    typedef logic [31:0]                 word_t;
    typedef logic [3:0]                  strb_t;
    typedef logic [`CACHE_WORDS*32-1:0]  line_t;

    // cpu request where op 1 is a store
    typedef struct packed {
        logic  op;
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
    } cpu_req_t;

    // what one way reports for the set being looked up
    typedef struct packed {
        logic  hit;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_rd_t;

    // write command into one way
    typedef struct packed {
        logic [`CACHE_WORDS-1:0] word_we;
        strb_t                   strb;
        line_t                   data;
        logic                    tag_we;
        tag_t                    tag;
        logic                    dirty_we;
        logic                    dirty;
    } way_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL,
        DONE
    } cache_state_e;

endpackage

//--- verilog/victim_lfsr.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module victim_lfsr (
    input  logic clk,
    input  logic resetn,
    output logic victim_way
);

    logic [22:0] lfsr_q;
    logic        feedback;

    // taps 22 and 17 give a maximal sequence
    assign feedback = lfsr_q[22] ^ lfsr_q[17];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr_q <= `CACHE_LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[21:0], feedback};
        end
    end

    assign victim_way = lfsr_q[0];

endmodule

//--- cache/cache_way.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_way
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  index_t  index,
    input  tag_t    lookup_tag,
    input  way_wr_t wr,
    output way_rd_t rd
);

    tag_t                   tag_mem [`CACHE_SETS];
    word_t                  bank_mem [`CACHE_WORDS][`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_bits;
    logic [`CACHE_SETS-1:0] dirty_bits;

    tag_t  tag_q;
    line_t line_q;
    logic  valid_q;
    logic  dirty_q;

    // per-set flags
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_q    <= 1'b0;
            dirty_q    <= 1'b0;
        end else begin
            if (wr.tag_we) begin
                valid_bits[index] <= 1'b1;
            end
            if (wr.dirty_we) begin
                dirty_bits[index] <= wr.dirty;
            end
            valid_q <= valid_bits[index];
            dirty_q <= dirty_bits[index];
        end
    end

    // tag array
    always_ff @(posedge clk) begin
        if (wr.tag_we) begin
            tag_mem[index] <= wr.tag;
        end
        tag_q <= tag_mem[index];
    end

    // word banks with an enable per byte lane
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WORDS; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.word_we[w] && wr.strb[b]) begin
                    bank_mem[w][index][8*b +: 8] <= wr.data[32*w + 8*b +: 8];
                end
            end
            line_q[32*w +: 32] <= bank_mem[w][index];
        end
    end

    // dirty only counts on a live line
    assign rd = '{
        hit:   valid_q && (tag_q == lookup_tag),
        dirty: valid_q && dirty_q,
        tag:   tag_q,
        line:  line_q
    };

endmodule

//--- cache/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     valid,
    input  cpu_req_t req,
    output logic     addr_ok,
    output logic     data_ok,
    output word_t    rdata,
    output logic     rd_req,
    output addr_t    rd_addr,
    input  logic     rd_rdy,
    input  logic     ret_valid,
    input  logic     ret_last,
    input  word_t    ret_data,
    output logic     wr_req,
    output addr_t    wr_addr,
    output line_t    wr_data,
    input  logic     wr_rdy,
    output index_t   array_index,
    output tag_t     lookup_tag,
    output way_wr_t  way0_wr,
    output way_wr_t  way1_wr,
    input  way_rd_t  way0_rd,
    input  way_rd_t  way1_rd,
    input  logic     victim_way
);

    cache_state_e state_q;
    cache_state_e state_d;
    cpu_req_t     req_q;
    logic         victim_q;
    logic         victim_dirty_q;
    tag_t         victim_tag_q;
    line_t        victim_line_q;
    word_sel_t    beat_q;
    word_t        rdata_q;
    way_rd_t      rd_w [2];
    way_wr_t      wr_w [2];
    index_t       req_index;
    word_sel_t    word_sel;
    logic         hit;
    line_t        hit_line;
    word_t        hit_word;
    word_t        fill_word;
    logic         hit_store;
    logic         fill_beat;

    function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = strb[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    assign req_index  = req_q.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign lookup_tag = req_q.addr[`CACHE_OFFSET_W + `CACHE_INDEX_W +: `CACHE_TAG_W];
    assign word_sel   = req_q.addr[`CACHE_OFFSET_W-1 -: 2];

    // arrays see the new index while the request is still being captured
    assign array_index = (state_q == IDLE) ?
                         req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W] : req_index;

    assign rd_w      = '{way0_rd, way1_rd};
    assign hit       = rd_w[0].hit | rd_w[1].hit;
    assign hit_line  = rd_w[0].hit ? rd_w[0].line : rd_w[1].line;
    assign hit_word  = hit_line[32*word_sel +: 32];
    assign hit_store = (state_q == LOOKUP) && hit && req_q.op;
    assign fill_beat = (state_q == REFILL) && ret_valid;

    // store miss folds its bytes into the target beat
    assign fill_word = (req_q.op && beat_q == word_sel) ?
                       merge_word(ret_data, req_q.wdata, req_q.wstrb) : ret_data;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE:    if (valid) state_d = LOOKUP;
            LOOKUP:  state_d = hit ? DONE : MISS;
            MISS:    if (!victim_dirty_q || wr_rdy) state_d = REPLACE;
            REPLACE: if (rd_rdy) state_d = REFILL;
            REFILL:  if (ret_valid && ret_last) state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q        <= IDLE;
            req_q          <= '0;
            victim_q       <= 1'b0;
            victim_dirty_q <= 1'b0;
            beat_q         <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && valid) begin
                req_q <= req;
            end
            if (state_q == LOOKUP) begin
                victim_q       <= victim_way;
                victim_dirty_q <= rd_w[victim_way].dirty;
            end
            if (state_q == REPLACE) begin
                beat_q <= '0;
            end else if (fill_beat) begin
                beat_q <= beat_q + 2'd1;
            end
        end
    end

    // victim line and read word
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP) begin
            victim_tag_q  <= rd_w[victim_way].tag;
            victim_line_q <= rd_w[victim_way].line;
        end
        if (state_q == LOOKUP && hit) begin
            rdata_q <= req_q.op ? merge_word(hit_word, req_q.wdata, req_q.wstrb) : hit_word;
        end else if (fill_beat && beat_q == word_sel) begin
            rdata_q <= fill_word;
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wr_w[w] = '0;
            if (hit_store && rd_w[w].hit) begin
                wr_w[w].word_we  = 4'b0001 << word_sel;
                wr_w[w].strb     = req_q.wstrb;
                wr_w[w].data     = {`CACHE_WORDS{req_q.wdata}};
                wr_w[w].dirty_we = 1'b1;
                wr_w[w].dirty    = 1'b1;
            end else if (fill_beat && victim_q == w[0]) begin
                wr_w[w].word_we  = 4'b0001 << beat_q;
                wr_w[w].strb     = '1;
                wr_w[w].data     = {`CACHE_WORDS{fill_word}};
                // tag, valid and dirty land with the last beat
                wr_w[w].tag_we   = ret_last;
                wr_w[w].tag      = lookup_tag;
                wr_w[w].dirty_we = ret_last;
                wr_w[w].dirty    = req_q.op;
            end
        end
    end

    assign way0_wr = wr_w[0];
    assign way1_wr = wr_w[1];

    assign addr_ok = (state_q == LOOKUP);
    assign data_ok = (state_q == DONE);
    assign rdata   = rdata_q;
    assign rd_req  = (state_q == REPLACE);
    assign rd_addr = {lookup_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_req  = (state_q == MISS) && victim_dirty_q;
    assign wr_addr = {victim_tag_q, req_index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_data = victim_line_q;

endmodule

//--- cache/cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    // cpu side
    input  logic     valid,
    input  cpu_req_t req,
    output logic     addr_ok,
    output logic     data_ok,
    output word_t    rdata,
    // line read channel
    output logic     rd_req,
    output addr_t    rd_addr,
    input  logic     rd_rdy,
    input  logic     ret_valid,
    input  logic     ret_last,
    input  word_t    ret_data,
    // line write channel
    output logic     wr_req,
    output addr_t    wr_addr,
    output line_t    wr_data,
    input  logic     wr_rdy
);

    index_t  array_index;
    tag_t    lookup_tag;
    way_wr_t way0_wr;
    way_wr_t way1_wr;
    way_rd_t way0_rd;
    way_rd_t way1_rd;
    logic    victim_way;

    cache_ctrl ctrl_i (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_rdy      (wr_rdy),
        .array_index (array_index),
        .lookup_tag  (lookup_tag),
        .way0_wr     (way0_wr),
        .way1_wr     (way1_wr),
        .way0_rd     (way0_rd),
        .way1_rd     (way1_rd),
        .victim_way  (victim_way)
    );

    cache_way way0_i (
        .clk        (clk),
        .resetn     (resetn),
        .index      (array_index),
        .lookup_tag (lookup_tag),
        .wr         (way0_wr),
        .rd         (way0_rd)
    );

    cache_way way1_i (
        .clk        (clk),
        .resetn     (resetn),
        .index      (array_index),
        .lookup_tag (lookup_tag),
        .wr         (way1_wr),
        .rd         (way1_rd)
    );

    victim_lfsr lfsr_i (
        .clk        (clk),
        .resetn     (resetn),
        .victim_way (victim_way)
    );

endmodule

//--- tests/cache_checker.sv
`timescale 1ns/1ps

module cache_checker
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     valid,
    input  cpu_req_t req,
    input  logic     addr_ok,
    input  logic     data_ok,
    input  word_t    rdata,
    input  logic     rd_req,
    input  addr_t    rd_addr,
    input  logic     rd_rdy,
    input  logic     ret_valid,
    input  logic     wr_req,
    input  addr_t    wr_addr,
    input  line_t    wr_data,
    input  logic     wr_rdy,
    output int       checks,
    output int       errors
);

    // words as the cpu has written them
    word_t    model [addr_t];
    bit       written [addr_t];
    cpu_req_t cur;
    addr_t    prev_line = '1;
    addr_t    held_addr;
    line_t    held_data;
    logic     started = 1'b0;
    logic     same_line = 1'b0;
    logic     rd_stalled = 1'b0;
    logic     wr_stalled = 1'b0;
    int       cycle = 0;
    int       ok_cycle = 0;
    int       beats = 0;
    int       grants = 0;
    int       n_checks = 0;
    int       n_errors = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    // never-written memory holds a pattern of its word address
    function automatic word_t stored_word(addr_t a);
        if (model.exists(a))
            return model[a];
        return (a * 32'h9e3779b1) ^ 32'h5c3ae017;
    endfunction

    task automatic record_check(input bit ok, input bit is_value, input string what);
        n_checks++;
        if (!ok) begin
            n_errors++;
            if (is_value)
                $display("mismatch at %0t: %s", $time, what);
            else
                $display("%s at %0t", what, $time);
        end
    endtask

    always @(negedge clk) begin
        addr_t a;
        word_t expected;
        if (resetn) begin
            cycle++;
            if (!started) begin
                record_check(!(addr_ok || data_ok || rd_req || wr_req), 1'b0,
                             "cache raised a strobe before any request");
                started = valid;
            end
            if (rd_stalled)
                record_check(rd_req && rd_addr == held_addr, 1'b0,
                             "read request changed while waiting for rd_rdy");
            if (wr_stalled)
                record_check(wr_req && wr_addr == held_addr && wr_data == held_data, 1'b0,
                             "write-back changed while waiting for wr_rdy");
            if (rd_req && rd_rdy) begin
                grants++;
                beats = 0;
                record_check(rd_addr == {cur.addr[31:4], 4'h0}, 1'b1,
                             $sformatf("rd_addr %h for request %h", rd_addr, cur.addr));
            end
            if (ret_valid)
                beats++;
            if (wr_req && wr_rdy) begin
                record_check(wr_addr[3:0] == 4'h0 && written.exists(wr_addr), 1'b0,
                             $sformatf("write-back of line %h the cpu never stored to", wr_addr));
                for (int w = 0; w < 4; w++) begin
                    a = wr_addr + 32'(4 * w);
                    record_check(wr_data[32*w +: 32] == stored_word(a), 1'b1,
                                 $sformatf("write-back word %h is %h, expected %h",
                                           a, wr_data[32*w +: 32], stored_word(a)));
                end
            end
            if (addr_ok) begin
                cur = req;
                ok_cycle = cycle;
                same_line = (prev_line == {req.addr[31:4], 4'h0});
                grants = 0;
                beats = 0;
            end
            if (data_ok) begin
                a = {cur.addr[31:2], 2'b00};
                expected = stored_word(a);
                for (int b = 0; b < 4; b++) begin
                    if (cur.op && cur.wstrb[b])
                        expected[8*b +: 8] = cur.wdata[8*b +: 8];
                end
                record_check(rdata == expected, 1'b1,
                             $sformatf("%s %h rdata %h, expected %h",
                                       cur.op ? "store" : "load", a, rdata, expected));
                if (cur.op) begin
                    model[a] = expected;
                    written[{a[31:4], 4'h0}] = 1'b1;
                end
                record_check(grants <= 1 && (grants == 0 || beats == 4), 1'b0,
                             "refill did not take one line read of four beats");
                if (same_line)
                    record_check(grants == 0 && cycle - ok_cycle == 1, 1'b0,
                                 "repeat access to the same line was not a two-cycle hit");
                prev_line = {a[31:4], 4'h0};
            end
            rd_stalled = rd_req && !rd_rdy;
            wr_stalled = wr_req && !wr_rdy;
            held_addr = rd_req ? rd_addr : wr_addr;
            held_data = wr_data;
        end
    end

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int RANDOM_REQS = 300;
    localparam int HIT_PAIRS   = 60;
    localparam int LIMIT       = 400 * (RANDOM_REQS + 2 * HIT_PAIRS);

    logic     clk;
    logic     resetn;
    logic     valid;
    cpu_req_t req;
    logic     addr_ok;
    logic     data_ok;
    word_t    rdata;
    logic     rd_req;
    addr_t    rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    logic     ret_last;
    word_t    ret_data;
    logic     wr_req;
    addr_t    wr_addr;
    line_t    wr_data;
    logic     wr_rdy;
    int       checks;
    int       errors;
    int       tests = 0;
    int       last_checks = 0;
    int       last_errors = 0;
    // lines written back by the cache keyed by line address
    line_t    mem_lines [addr_t];

    cache_top dut_i (.*);
    cache_checker checker_i (.*);

    function automatic word_t mem_word(addr_t a);
        line_t stored;
        if (!mem_lines.exists({a[31:4], 4'h0}))
            return (a * 32'h9e3779b1) ^ 32'h5c3ae017;
        stored = mem_lines[{a[31:4], 4'h0}];
        return stored[{a[3:2], 5'b0} +: 32];
    endfunction

    function automatic cpu_req_t random_request();
        cpu_req_t r;
        tag_t     tag;
        index_t   index;
        // 8 tags over 4 sets keeps both ways evicting
        tag     = 20'h1c000 + 20'($urandom % 8) * 20'h00b35;
        index   = 8'($urandom % 4) * 8'd61;
        r.op    = 1'($urandom);
        r.addr  = {tag, index, 2'($urandom), 2'b00};
        r.wstrb = 4'($urandom);
        r.wdata = $urandom;
        return r;
    endfunction

    task automatic send_request(input cpu_req_t r);
        @(posedge clk);
        valid <= 1'b1;
        req   <= r;
        @(negedge clk);
        while (!addr_ok)
            @(negedge clk);
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        while (!data_ok)
            @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        tests++;
        $display("test %s: %0d checks, %0d errors", name,
                 checks - last_checks, errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("watchdog expired after %0d cycles without a result", LIMIT);
        $display("Regression failed");
        $finish;
    end

    // read channel of the memory model
    initial begin
        addr_t line_a;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                line_a = rd_addr;
                repeat ($urandom % 4) @(negedge clk);
                @(posedge clk);
                rd_rdy <= 1'b1;
                @(posedge clk);
                rd_rdy <= 1'b0;
                for (int b = 0; b < 4; b++) begin
                    ret_valid <= 1'b0;
                    repeat ($urandom % 3) @(posedge clk);
                    ret_valid <= 1'b1;
                    ret_last  <= (b == 3);
                    ret_data  <= mem_word(line_a + 32'(4 * b));
                    @(posedge clk);
                end
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
            end
        end
    end

    // write channel of the memory model
    initial begin
        wr_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (wr_req) begin
                repeat ($urandom % 4) @(negedge clk);
                mem_lines[wr_addr] = wr_data;
                @(posedge clk);
                wr_rdy <= 1'b1;
                @(posedge clk);
                wr_rdy <= 1'b0;
            end
        end
    end

    initial begin
        cpu_req_t r;
        void'($urandom(93));
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        // outputs stay low through this quiet window
        repeat (10) @(posedge clk);
        finish_test("reset_idle");
        for (int i = 0; i < RANDOM_REQS; i++) begin
            send_request(random_request());
        end
        finish_test("random_traffic");
        for (int i = 0; i < HIT_PAIRS; i++) begin
            r = random_request();
            send_request(r);
            r.op        = 1'b0;
            r.addr[3:2] = 2'($urandom);
            send_request(r);
        end
        finish_test("hit_latency");
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+common
common/cache_pkg.sv
verilog/victim_lfsr.sv
cache/cache_way.sv
cache/cache_ctrl.sv
cache/cache_top.sv
tests/cache_checker.sv
tests/cache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module cache_tb -Mdir obj_dir -o cache_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/cache_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
